// File: build.f
verilog/iomem_pkg.sv
verilog/rx_write_translator.sv
verilog/tx_global_reader.sv
verilog/ctrl_packet_rom.sv
verilog/io_memory_bridge.sv
dv/io_memory_bridge_sva.sv
dv/tb_io_memory_bridge.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_io_memory_bridge \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0

// File: dv/tb_io_memory_bridge.sv
`timescale 1ns/1ns

module tb_io_memory_bridge;

    import iomem_pkg::*;

    localparam int ACK_TIMEOUT = 20;
    localparam int MEM_WORDS   = 8192;

    logic              clock;
    logic              reset;
    logic [31:0]       wb_adr;
    logic [3:0]        wb_sel;
    logic              wb_we;
    logic              wb_cyc;
    logic              wb_stb;
    logic [31:0]       wb_dat;
    logic              wb_ack;
    logic [31:0]       wb_rdat;
    logic [31:0]       mem_addr;
    logic [31:0]       mem_data;
    logic [4:0]        mem_we;
    logic              mem_gl_en;
    logic [31:0]       mem_rdata;
    logic [15:0]       arq_n;
    logic [15:0]       tx_len;
    logic [15:0]       total_packets;
    logic [15:0]       lfsr_state;
    logic [31:0]       mem [0:MEM_WORDS-1];
    int                we_edges = 0;
    int                gl_edges = 0;
    logic [15:0]       cur_len;
    logic [15:0]       cur_id;
    logic [15:0]       cur_n;
    logic [15:0]       valid_ids [0:8];

    io_memory_bridge u_io_memory_bridge (
        .clock           (clock),
        .reset           (reset),
        .wb_adr_i        (wb_adr),
        .wb_sel_i        (wb_sel),
        .wb_we_i         (wb_we),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_dat_i        (wb_dat),
        .wb_ack_o        (wb_ack),
        .wb_dat_o        (wb_rdat),
        .mem_addr_o      (mem_addr),
        .mem_data_o      (mem_data),
        .mem_we_o        (mem_we),
        .mem_gl_en_o     (mem_gl_en),
        .mem_rdata_i     (mem_rdata),
        .arq_n_i         (arq_n),
        .tx_len_o        (tx_len),
        .total_packets_o (total_packets)
    );

    always #50 clock = ~clock;

    // registered memory, bank writes and global read cycles only counted
    always @(posedge clock) begin
        mem_rdata <= mem[mem_addr[12:0]];
        if (mem_we != 5'd0) begin
            we_edges <= we_edges + 1;
        end
        if (mem_gl_en) begin
            gl_edges <= gl_edges + 1;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] mem_fill(input int index);
        return (32'(index) * 32'h0001_0007) ^ 32'hc3a5_0000;
    endfunction

    function automatic logic [4:0] bank_for(input logic [15:0] id);
        case (id)
            16'h0000, 16'h0001: return 5'b00001;
            16'h0100, 16'h0101: return 5'b00010;
            16'h0200, 16'h0201: return 5'b00100;
            16'h0300, 16'h0301: return 5'b01000;
            16'h0400:           return 5'b10000;
            default:            return 5'b00000;
        endcase
    endfunction

    function automatic logic [31:0] ctrl_expect(input int byte_adr, input logic arq,
                                                input logic [15:0] seq);
        case (byte_adr / 4)
            0:       return 32'h484f_5354;
            1:       return 32'h5043_5055;
            2:       return 32'h5249_5343;
            3:       return 32'h0;
            4:       return {16'd64, 16'd0};
            5:       return {16'd0, 16'd1};
            6:       return arq ? {seq, 16'hfafa} : 32'h00fa_fafa;
            default: return 32'hfafa_fafa;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopping at first error");
        end
    endtask

    // one bus transfer, returns the ack cycle and what the DUT showed then
    task automatic transfer(input logic [31:0] adr, input logic [31:0] dat, input logic we,
                            output int cycles, output logic [31:0] rdata,
                            output logic [31:0] maddr, output logic [31:0] mdata,
                            output logic [4:0] mwe);
        int n;
        @(negedge clock);
        wb_adr = adr;
        wb_dat = dat;
        wb_we  = we;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        for (n = 1; n <= ACK_TIMEOUT; n++) begin
            #10;
            if (wb_ack) begin
                break;
            end
            @(negedge clock);
        end
        if (n > ACK_TIMEOUT) begin
            $display("timeout at %0t ns: no acknowledge for address %h", $time, adr);
            $display("=== FAIL ===");
            $fatal(1, "acknowledge timeout");
        end
        cycles = n;
        rdata  = wb_rdat;
        maddr  = mem_addr;
        mdata  = mem_data;
        mwe    = mem_we;
        @(negedge clock);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_header(input logic [15:0] len, input logic [15:0] id,
                                input logic [15:0] n, input logic [15:0] total);
        int          cycles;
        logic [31:0] rdata;
        logic [31:0] maddr;
        logic [31:0] mdata;
        logic [4:0]  mwe;
        logic [31:0] dat;
        for (int w = 0; w < 6; w++) begin
            dat = (w == 4) ? {len, id} : ((w == 5) ? {n, total} : rand_bits(32));
            transfer(32'(w * 4), dat, 1'b1, cycles, rdata, maddr, mdata, mwe);
            check("header ack cycle", 32'(cycles), 32'd1);
            check("header bank enable", {27'd0, mwe}, 32'd0);
        end
        cur_len = len;
        cur_id  = id;
        cur_n   = n;
        check("total_packets_o", {16'd0, total_packets}, {16'd0, total});
    endtask

    task automatic data_writes(input int count);
        int          cycles;
        int          edges_before;
        logic [31:0] rdata;
        logic [31:0] maddr;
        logic [31:0] mdata;
        logic [4:0]  mwe;
        logic [21:0] idx;
        logic [31:0] dat;
        logic [31:0] exp_addr;
        logic [31:0] bias;
        for (int k = 0; k < count; k++) begin
            idx  = 22'd6 + 22'(rand_bits(10));
            dat  = rand_bits(32);
            bias = (cur_id == 16'h0400) ? 32'd10 : 32'd26;
            exp_addr = {10'd0, idx} + ({16'd0, cur_n} * {18'd0, cur_len[15:2]}) + bias;
            edges_before = we_edges;
            transfer({8'd0, idx, 2'b00}, dat, 1'b1, cycles, rdata, maddr, mdata, mwe);
            check("write ack cycle", 32'(cycles), 32'd4);
            check("write bank enable", {27'd0, mwe}, {27'd0, bank_for(cur_id)});
            if (bank_for(cur_id) != 5'd0) begin
                check("write address", maddr, exp_addr);
                check("write data", mdata, dat);
                check("bank write cycles", 32'(we_edges - edges_before), 32'd4);
            end else begin
                check("bank write cycles", 32'(we_edges - edges_before), 32'd0);
            end
        end
    endtask

    task automatic ctrl_reads(input logic arq);
        int          cycles;
        logic [31:0] rdata;
        logic [31:0] maddr;
        logic [31:0] mdata;
        logic [4:0]  mwe;
        logic [31:0] base;
        arq_n = rand_bits(16);
        base  = arq ? 32'h8000_0000 : 32'h4000_0000;
        for (int b = 0; b <= 32; b += 4) begin
            transfer(base | 32'(b), 32'd0, 1'b0, cycles, rdata, maddr, mdata, mwe);
            check("control ack cycle", 32'(cycles), 32'd3);
            check("control word", rdata, ctrl_expect(b, arq, arq_n));
        end
    endtask

    task automatic global_reads();
        int          cycles;
        int          edges_before;
        logic [31:0] rdata;
        logic [31:0] maddr;
        logic [31:0] mdata;
        logic [4:0]  mwe;
        logic [31:0] ptr;
        logic [15:0] len;
        logic [31:0] exp_data;
        ptr = 32'h200 + rand_bits(11);
        len = 16'd1 + 16'(rand_bits(4));
        mem[TX_PTR_WORD[12:0]] = ptr;
        mem[TX_LEN_WORD[12:0]] = {rand_bits(16), len};
        for (int idx = 0; idx < int'(len) + 3; idx++) begin
            exp_data = (idx < int'(len)) ? mem[13'(ptr + 32'(idx))] : 32'd0;
            edges_before = gl_edges;
            transfer(32'h2000_0000 | 32'(idx * 4), 32'd0, 1'b0, cycles, rdata, maddr,
                     mdata, mwe);
            check("global ack cycle", 32'(cycles), 32'd7);
            check("global data", rdata, exp_data);
            check("tx_len_o", {16'd0, tx_len}, {16'd0, len});
            // enable held from cycle 1 through the ack cycle
            check("global enable cycles", 32'(gl_edges - edges_before), 32'd7);
        end
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        wb_adr     = '0;
        wb_sel     = 4'hf;
        wb_we      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_dat     = '0;
        arq_n      = '0;
        lfsr_state = 16'd90;
        valid_ids  = '{16'h0000, 16'h0001, 16'h0100, 16'h0101, 16'h0200,
                       16'h0201, 16'h0300, 16'h0301, 16'h0400};
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = mem_fill(i);
        end
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #10;
        check("ack after reset", {31'd0, wb_ack}, 32'd0);
        check("bank enable after reset", {27'd0, mem_we}, 32'd0);
        check("global enable after reset", {31'd0, mem_gl_en}, 32'd0);
        check("total after reset", {16'd0, total_packets}, 32'd0);
        check("tx_len after reset", {16'd0, tx_len}, 32'd0);
        check("read data after reset", wb_rdat, 32'd0);

        for (int r = 0; r < 4; r++) begin
            write_header({14'(rand_bits(14)), 2'b00}, valid_ids[rand_bits(4) % 9],
                         rand_bits(16), rand_bits(16));
            data_writes(6);
        end
        // mem_id 0x0fxx is outside the bank table
        write_header({14'(rand_bits(14)), 2'b00}, {8'h0f, 8'(rand_bits(8))},
                     rand_bits(16), rand_bits(16));
        data_writes(3);

        ctrl_reads(1'b1);
        ctrl_reads(1'b0);
        global_reads();
        global_reads();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: dv/io_memory_bridge_sva.sv
`timescale 1ns/1ns

module io_memory_bridge_sva (
    input logic                            clock,
    input logic                            reset,
    input logic                            cyc_i,
    input logic                            stb_i,
    input logic                            we_i,
    input logic                            ack_i,
    input logic [iomem_pkg::NUM_BANKS-1:0] bank_we_i,
    input logic                            gl_en_i
);

    ack_needs_strobe: assert property (@(posedge clock) disable iff (reset)
        ack_i |-> (cyc_i && stb_i))
        else $error("acknowledge without cycle and strobe");

    // bank enables belong to write transfers only
    bank_we_on_write: assert property (@(posedge clock) disable iff (reset)
        (bank_we_i != '0) |-> (cyc_i && stb_i && we_i))
        else $error("bank write enable outside a write");

    gl_en_on_read: assert property (@(posedge clock) disable iff (reset)
        gl_en_i |-> (cyc_i && stb_i && !we_i))
        else $error("global read enable outside a read");

endmodule

bind io_memory_bridge io_memory_bridge_sva u_io_memory_bridge_sva (
    .clock     (clock),
    .reset     (reset),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .we_i      (wb_we_i),
    .ack_i     (wb_ack_o),
    .bank_we_i (mem_we_o),
    .gl_en_i   (mem_gl_en_o)
);

// File: verilog/io_memory_bridge.sv
`timescale 1ns/1ns

module io_memory_bridge #(
    parameter int WRITE_WAIT     = 3,
    parameter int TX_META_CYCLES = iomem_pkg::TX_META_CYCLES,
    parameter int CTRL_ACK_WAIT  = iomem_pkg::CTRL_ACK_WAIT
) (
    input  logic                             clock,
    input  logic                             reset,
    // slave port driven by the MAC
    input  logic [iomem_pkg::ADDR_W-1:0]     wb_adr_i,
    input  logic [3:0]                       wb_sel_i,
    input  logic                             wb_we_i,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic [iomem_pkg::DATA_W-1:0]     wb_dat_i,
    output logic                             wb_ack_o,
    output logic [iomem_pkg::DATA_W-1:0]     wb_dat_o,
    // banked memory
    output logic [iomem_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic [iomem_pkg::DATA_W-1:0]     mem_data_o,
    output logic [iomem_pkg::NUM_BANKS-1:0]  mem_we_o,
    output logic                             mem_gl_en_o,
    input  logic [iomem_pkg::DATA_W-1:0]     mem_rdata_i,
    // packet info
    input  logic [iomem_pkg::HALF_W-1:0]     arq_n_i,
    output logic [iomem_pkg::HALF_W-1:0]     tx_len_o,
    output logic [iomem_pkg::HALF_W-1:0]     total_packets_o
);

    import iomem_pkg::*;

    wb_req_t           wb_req;
    mem_req_t          rx_mem;
    mem_req_t          gl_mem;
    mem_req_t          mem_req;
    logic [DATA_W-1:0] lane_mask;
    logic              rx_sel;
    logic              gl_sel;
    logic              ctrl_sel;
    logic              rx_ack;
    logic              gl_ack;
    logic              ctrl_ack;
    logic [DATA_W-1:0] gl_rdata;
    logic [DATA_W-1:0] ctrl_rdata;

    // unselected byte lanes are written as zero
    assign lane_mask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}},
                        {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};

    assign wb_req.adr = wb_adr_i;
    assign wb_req.dat = wb_dat_i & lane_mask;
    assign wb_req.we  = wb_we_i;
    assign wb_req.stb = wb_cyc_i & wb_stb_i;

    // request decode, bit 29 wins over the control packets
    assign rx_sel   = wb_req.stb && wb_req.we;
    assign gl_sel   = wb_req.stb && !wb_req.we && wb_req.adr[29];
    assign ctrl_sel = wb_req.stb && !wb_req.we && !wb_req.adr[29] &&
                      (wb_req.adr[31] || wb_req.adr[30]);

    rx_write_translator #(
        .WRITE_WAIT (WRITE_WAIT)
    ) u_rx_write_translator (
        .clock           (clock),
        .reset           (reset),
        .req_i           (wb_req),
        .sel_i           (rx_sel),
        .mem_o           (rx_mem),
        .ack_o           (rx_ack),
        .total_packets_o (total_packets_o)
    );

    tx_global_reader #(
        .TX_META_CYCLES (TX_META_CYCLES)
    ) u_tx_global_reader (
        .clock       (clock),
        .reset       (reset),
        .req_i       (wb_req),
        .sel_i       (gl_sel),
        .mem_o       (gl_mem),
        .mem_rdata_i (mem_rdata_i),
        .rdata_o     (gl_rdata),
        .ack_o       (gl_ack),
        .tx_len_o    (tx_len_o)
    );

    ctrl_packet_rom #(
        .CTRL_ACK_WAIT (CTRL_ACK_WAIT)
    ) u_ctrl_packet_rom (
        .clock    (clock),
        .reset    (reset),
        .req_i    (wb_req),
        .sel_i    (ctrl_sel),
        .is_arq_i (wb_req.adr[31]),
        .arq_n_i  (arq_n_i),
        .rdata_o  (ctrl_rdata),
        .ack_o    (ctrl_ack)
    );

    // response mux
    assign wb_ack_o = rx_ack | gl_ack | ctrl_ack;
    assign wb_dat_o = gl_sel ? gl_rdata : (ctrl_sel ? ctrl_rdata : '0);

    // memory port follows the active request, idle otherwise
    assign mem_req = rx_sel ? rx_mem : (gl_sel ? gl_mem : '0);

    assign mem_addr_o  = mem_req.addr;
    assign mem_data_o  = mem_req.data;
    assign mem_we_o    = mem_req.we;
    assign mem_gl_en_o = mem_req.gl_en;

endmodule

// File: verilog/ctrl_packet_rom.sv
`timescale 1ns/1ns

module ctrl_packet_rom #(
    parameter int CTRL_ACK_WAIT = iomem_pkg::CTRL_ACK_WAIT
) (
    input  logic                          clock,
    input  logic                          reset,
    input  iomem_pkg::wb_req_t            req_i,
    input  logic                          sel_i,
    input  logic                          is_arq_i,
    input  logic [iomem_pkg::HALF_W-1:0]  arq_n_i,
    output logic [iomem_pkg::DATA_W-1:0]  rdata_o,
    output logic                          ack_o
);

    import iomem_pkg::*;

    localparam int CNT_W = (CTRL_ACK_WAIT > 0) ? $clog2(CTRL_ACK_WAIT + 1) : 1;
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(CTRL_ACK_WAIT);

    // ascii "HOST", "PCPU", "RISC"
    localparam logic [DATA_W-1:0] WORD_HOST = 32'h484f_5354;
    localparam logic [DATA_W-1:0] WORD_PCPU = 32'h5043_5055;
    localparam logic [DATA_W-1:0] WORD_RISC = 32'h5249_5343;
    localparam logic [DATA_W-1:0] WORD_FILL = 32'hfafa_fafa;

    logic [CNT_W-1:0]  wait_cnt;
    logic [21:0]       word_idx;

    assign word_idx = req_i.adr[23:2];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!sel_i) begin
            wait_cnt <= '0;
        end else if (wait_cnt < WAIT_LAST) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_comb begin
        case (word_idx)
            22'd0:   rdata_o = WORD_HOST;
            22'd1:   rdata_o = WORD_PCPU;
            22'd2:   rdata_o = WORD_RISC;
            // reserved and packet type
            22'd3:   rdata_o = '0;
            // length 64, mem_id 0
            22'd4:   rdata_o = {16'd64, 16'd0};
            // n 0, one packet in total
            22'd5:   rdata_o = {16'd0, 16'd1};
            22'd6:   rdata_o = is_arq_i ? {arq_n_i, 16'hfafa} : 32'h00fa_fafa;
            default: rdata_o = WORD_FILL;
        endcase
    end

    assign ack_o = sel_i && (wait_cnt >= WAIT_LAST);

endmodule

// File: verilog/tx_global_reader.sv
`timescale 1ns/1ns

module tx_global_reader #(
    parameter int TX_META_CYCLES = iomem_pkg::TX_META_CYCLES
) (
    input  logic                          clock,
    input  logic                          reset,
    input  iomem_pkg::wb_req_t            req_i,
    input  logic                          sel_i,
    output iomem_pkg::mem_req_t           mem_o,
    input  logic [iomem_pkg::DATA_W-1:0]  mem_rdata_i,
    output logic [iomem_pkg::DATA_W-1:0]  rdata_o,
    output logic                          ack_o,
    output logic [iomem_pkg::HALF_W-1:0]  tx_len_o
);

    import iomem_pkg::*;

    localparam int CNT_W = $clog2(TX_META_CYCLES + 2);

    // last cycle count presenting the pointer word
    localparam logic [CNT_W-1:0] PTR_LAST = CNT_W'(TX_META_CYCLES - 2);
    // count presenting the length word
    localparam logic [CNT_W-1:0] LEN_CYC  = CNT_W'(TX_META_CYCLES - 1);
    // first data address cycle, length word is back from memory
    localparam logic [CNT_W-1:0] DATA_CYC = CNT_W'(TX_META_CYCLES);
    localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(TX_META_CYCLES + 1);

    logic [CNT_W-1:0]  cyc_cnt;
    logic [DATA_W-1:0] tx_ptr;
    logic [HALF_W-1:0] tx_len;
    logic              data_ready;
    logic [ADDR_W-1:0] word_idx;
    logic              in_range;

    assign word_idx = {5'd0, req_i.adr[28:2]};
    assign in_range = word_idx < {16'd0, tx_len};

    // cycle counter and ready flag, both restart with the strobe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cyc_cnt    <= '0;
            data_ready <= 1'b0;
        end else if (!sel_i) begin
            cyc_cnt    <= '0;
            data_ready <= 1'b0;
        end else begin
            if (cyc_cnt < CNT_MAX) begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
            if (cyc_cnt == DATA_CYC) begin
                data_ready <= 1'b1;
            end
        end
    end

    // pointer arrives while its address is still held
    always_ff @(posedge clock) begin
        if (sel_i && (cyc_cnt == PTR_LAST)) begin
            tx_ptr <= mem_rdata_i;
        end
    end

    // length lands one cycle after its address
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tx_len <= '0;
        end else if (sel_i && (cyc_cnt == DATA_CYC)) begin
            tx_len <= mem_rdata_i[HALF_W-1:0];
        end
    end

    always_comb begin
        mem_o = '0;
        if (sel_i) begin
            mem_o.gl_en = 1'b1;
            if (cyc_cnt <= PTR_LAST) begin
                mem_o.addr = TX_PTR_WORD;
            end else if (cyc_cnt == LEN_CYC) begin
                mem_o.addr = TX_LEN_WORD;
            end else begin
                mem_o.addr = tx_ptr + word_idx;
            end
        end
    end

    // words past the length are padding
    assign rdata_o = (sel_i && data_ready && in_range) ? mem_rdata_i : '0;

    assign ack_o    = sel_i && data_ready;
    assign tx_len_o = tx_len;

endmodule

// File: verilog/rx_write_translator.sv
`timescale 1ns/1ns

module rx_write_translator #(
    parameter int WRITE_WAIT = 3
) (
    input  logic                          clock,
    input  logic                          reset,
    input  iomem_pkg::wb_req_t            req_i,
    input  logic                          sel_i,
    output iomem_pkg::mem_req_t           mem_o,
    output logic                          ack_o,
    output logic [iomem_pkg::HALF_W-1:0]  total_packets_o
);

    import iomem_pkg::*;

    localparam int CNT_W = (WRITE_WAIT > 0) ? $clog2(WRITE_WAIT + 1) : 1;
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WRITE_WAIT);

    rx_header_t           hdr;
    logic [ADDR_W-1:0]    addr_offset;
    logic [CNT_W-1:0]     wait_cnt;
    logic                 hdr_write;
    logic                 data_write;
    logic [ADDR_W-1:0]    word_idx;
    logic [ADDR_W-1:0]    bias;
    logic [NUM_BANKS-1:0] bank_we;

    // header words sit below byte 24, payload follows
    assign hdr_write  = sel_i && (req_i.adr < HDR_LEN_BYTES);
    assign data_write = sel_i && (req_i.adr >= HDR_LEN_BYTES);

    // header capture
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hdr         <= '0;
            addr_offset <= '0;
        end else if (hdr_write) begin
            if (req_i.adr == HDR_LEN_MEMID_ADR) begin
                hdr.length <= req_i.dat[31:16];
                hdr.mem_id <= req_i.dat[15:0];
            end else if (req_i.adr == HDR_N_TOTAL_ADR) begin
                hdr.n     <= req_i.dat[31:16];
                hdr.total <= req_i.dat[15:0];
                // packet n starts n packet lengths in, counted in words
                addr_offset <= ADDR_W'(req_i.dat[31:16]) * ADDR_W'(hdr.length >> 2);
            end
        end
    end

    // wait counter, restarts whenever the strobe drops
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!sel_i) begin
            wait_cnt <= '0;
        end else if (wait_cnt < WAIT_LAST) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // mem_id to bank decode
    always_comb begin
        case (hdr.mem_id)
            16'h0000, 16'h0001: bank_we = 5'b00001;
            16'h0100, 16'h0101: bank_we = 5'b00010;
            16'h0200, 16'h0201: bank_we = 5'b00100;
            16'h0300, 16'h0301: bank_we = 5'b01000;
            GLOBAL_MEM_ID:      bank_we = 5'b10000;
            // unknown destination, write is dropped but still acked
            default:            bank_we = 5'b00000;
        endcase
    end

    assign word_idx = {10'd0, req_i.adr[23:2]};
    assign bias     = (hdr.mem_id == GLOBAL_MEM_ID) ? GLOBAL_BIAS : LOCAL_BIAS;

    always_comb begin
        mem_o = '0;
        if (data_write) begin
            mem_o.addr = word_idx + addr_offset + bias;
            mem_o.data = req_i.dat;
            mem_o.we   = bank_we;
        end
    end

    // header writes ack at once, data writes after the memory wait
    assign ack_o = hdr_write || (data_write && (wait_cnt >= WAIT_LAST));

    assign total_packets_o = hdr.total;

endmodule

// File: verilog/iomem_pkg.sv
package iomem_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int HALF_W = 16;

    // one write enable per memory bank, bank 4 is global
    localparam int NUM_BANKS = 5;

    // receive header layout, byte addresses as issued by the MAC
    localparam logic [ADDR_W-1:0] HDR_LEN_BYTES     = 32'd24;
    localparam logic [ADDR_W-1:0] HDR_LEN_MEMID_ADR = 32'd16;
    localparam logic [ADDR_W-1:0] HDR_N_TOTAL_ADR   = 32'd20;

    // mem_id of the global memory
    localparam logic [HALF_W-1:0] GLOBAL_MEM_ID = 16'h0400;

    // word address bias per destination
    localparam logic [ADDR_W-1:0] GLOBAL_BIAS = 32'd10;
    // bootloader size minus the header words
    localparam logic [ADDR_W-1:0] LOCAL_BIAS  = 32'd26;

    // transmit metadata words in global memory
    localparam logic [ADDR_W-1:0] TX_PTR_WORD = 32'h0000_0011;
    localparam logic [ADDR_W-1:0] TX_LEN_WORD = 32'h0000_0010;

    // default timing
    localparam int CTRL_ACK_WAIT  = 2;
    localparam int TX_META_CYCLES = 5;

    // request from the MAC, stb is cycle and strobe combined
    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic              we;
        logic              stb;
    } wb_req_t;

    // request towards the banked memory
    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    data;
        logic [NUM_BANKS-1:0] we;
        logic                 gl_en;
    } mem_req_t;

    // receive packet header fields
    typedef struct packed {
        logic [HALF_W-1:0] length;
        logic [HALF_W-1:0] mem_id;
        logic [HALF_W-1:0] n;
        logic [HALF_W-1:0] total;
    } rx_header_t;

endpackage
